// File: logic/mips_bus_pkg.sv
/*
 * Core level definitions
 * Data word, start and halt addresses, control state
 */

package mips_bus_pkg;

    typedef logic [31:0] word_t;

    // ------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------
    localparam word_t reset_vector = 32'hBFC0_0000; // First fetch after reset
    localparam word_t halt_address = 32'h0000_0000; // Core stops here

    // ------------------------------------------------------------
    // Control state
    // ------------------------------------------------------------
    typedef enum logic {
        state_fetch   = 1'b0,
        state_execute = 1'b1
    } state_t;

endpackage

// File: logic/mips_isa_pkg.sv
/*
 * MIPS subset instruction set definitions
 * Opcodes, function codes, ALU operations and the instruction word views
 */

package mips_isa_pkg;

    typedef enum logic [5:0] {
        opcode_rtype = 6'b00_0000,
        opcode_j     = 6'b00_0010,
        opcode_jal   = 6'b00_0011,
        opcode_addiu = 6'b00_1001,
        opcode_andi  = 6'b00_1100,
        opcode_ori   = 6'b00_1101,
        opcode_xori  = 6'b00_1110
    } opcode_t;

    typedef enum logic [5:0] {
        funct_jr   = 6'b00_1000,
        funct_addu = 6'b10_0001,
        funct_and  = 6'b10_0100,
        funct_or   = 6'b10_0101,
        funct_xor  = 6'b10_0110
    } funct_t;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_or,
        alu_xor
    } alu_op_t;

    // ------------------------------------------------------------
    // Instruction word, one 32-bit word seen three ways
    // ------------------------------------------------------------
    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_t     funct;
    } r_type_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_type_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] target;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        j_type_t j;
    } instr_t;

    localparam logic [4:0] reg_v0 = 5'd2;  // Result register, exported
    localparam logic [4:0] reg_ra = 5'd31; // Link register for JAL

endpackage

// File: logic/regfile_if.sv
/*
 * Register file port bundle
 * Two read addresses with their data, and one write port
 */

`timescale 1ns/1ps

interface regfile_if;

    logic [4:0]          rs_addr;
    logic [4:0]          rt_addr;
    logic                wr_en;
    logic [4:0]          wr_addr;
    mips_bus_pkg::word_t wr_data;
    mips_bus_pkg::word_t rs_data;
    mips_bus_pkg::word_t rt_data;

    modport ctrl (
        output rs_addr, rt_addr, wr_en, wr_addr, wr_data,
        input  rs_data, rt_data
    );

    modport regs (
        input  rs_addr, rt_addr, wr_en, wr_addr, wr_data,
        output rs_data, rt_data
    );

endinterface

// File: logic/reg_file.sv
/*
 * General purpose register file, 32 words
 * Two combinational read ports, one synchronous write port, r0 reads zero
 */

`timescale 1ns/1ps

module reg_file (
    input  logic                clk,
    input  logic                reset,
    regfile_if.regs             rf,
    output mips_bus_pkg::word_t register_v0
);

    mips_bus_pkg::word_t regs [32];

    // ------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int n = 0; n < 32; n++) begin
                regs[n] <= '0;
            end
        end else if (rf.wr_en && rf.wr_addr != 5'd0) begin // r0 stays zero
            regs[rf.wr_addr] <= rf.wr_data;
        end
    end

    // ------------------------------------------------------------
    // Read ports
    // ------------------------------------------------------------
    assign rf.rs_data = regs[rf.rs_addr];
    assign rf.rt_data = regs[rf.rt_addr];

    assign register_v0 = regs[mips_isa_pkg::reg_v0]; // Observation tap

endmodule

// File: logic/alu.sv
/*
 * Combinational ALU
 * Add with wraparound and the three bitwise operations
 */

`timescale 1ns/1ps

module alu (
    input  mips_bus_pkg::word_t   a,
    input  mips_bus_pkg::word_t   b,
    input  mips_isa_pkg::alu_op_t op,
    output mips_bus_pkg::word_t   result
);

    always_comb begin
        case (op)
            mips_isa_pkg::alu_add: begin
                result = a + b; // Carry out is dropped
            end
            mips_isa_pkg::alu_and: begin
                result = a & b;
            end
            mips_isa_pkg::alu_or: begin
                result = a | b;
            end
            mips_isa_pkg::alu_xor: begin
                result = a ^ b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: logic/pc_counter.sv
/*
 * Program counter
 * Steps by four, takes absolute or register jumps, flags the halt address
 */

`timescale 1ns/1ps

module pc_counter (
    input  logic                clk,
    input  logic                reset,
    input  logic                advance,
    input  logic                jump,
    input  logic                jump_reg,
    input  logic [25:0]         target,
    input  mips_bus_pkg::word_t reg_value,
    output mips_bus_pkg::word_t pc,
    output logic                halted
);

    mips_bus_pkg::word_t pc_plus4;
    mips_bus_pkg::word_t pc_next;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        if (jump_reg) begin
            pc_next = reg_value;                           // JR
        end else if (jump) begin
            pc_next = {pc_plus4[31:28], target, 2'b00};    // J and JAL
        end else if (advance) begin
            pc_next = pc_plus4;
        end else begin
            pc_next = pc;                                  // Hold during fetch
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= mips_bus_pkg::reset_vector;
            halted <= 1'b0;
        end else begin
            pc     <= pc_next;
            halted <= (pc_next == mips_bus_pkg::halt_address); // Tracks pc
        end
    end

endmodule

// File: logic/cpu_control.sv
/*
 * Fetch and execute control
 * Holds the state and instruction register, decodes and steers the datapath
 */

`timescale 1ns/1ps

module cpu_control (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  halted,
    input  mips_bus_pkg::word_t   pc,
    input  logic                  waitrequest,
    input  mips_bus_pkg::word_t   readdata,
    output logic                  read,
    output logic [3:0]            byteenable,
    regfile_if.ctrl               rf,
    output mips_isa_pkg::alu_op_t alu_op,
    output mips_bus_pkg::word_t   alu_b,
    input  mips_bus_pkg::word_t   alu_result,
    output logic                  pc_advance,
    output logic                  pc_jump,
    output logic                  pc_jump_reg,
    output logic [25:0]           jump_target
);

    mips_bus_pkg::state_t state;
    mips_isa_pkg::instr_t ir;

    mips_bus_pkg::word_t pc_plus4;
    logic                in_execute;
    logic                dec_write;     // Instruction writes a register
    logic                dec_jump;
    logic                dec_jump_reg;
    logic [4:0]          dec_wr_addr;
    mips_bus_pkg::word_t dec_wr_data;

    // ------------------------------------------------------------
    // State and instruction register
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mips_bus_pkg::state_fetch;
        end else if (state == mips_bus_pkg::state_fetch) begin
            if (!halted && !waitrequest) begin
                state <= mips_bus_pkg::state_execute; // Word taken this cycle
            end
        end else begin
            state <= mips_bus_pkg::state_fetch;       // Execute is one cycle
        end
    end

    always_ff @(posedge clk) begin
        if (state == mips_bus_pkg::state_fetch && !halted && !waitrequest) begin
            ir <= readdata; // Zero-latency slave
        end
    end

    // Bus read, kept low in reset and once halted
    assign read       = (state == mips_bus_pkg::state_fetch) && !halted && !reset;
    assign byteenable = read ? 4'b1111 : 4'b0000;

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------
    assign pc_plus4   = pc + 32'd4;
    assign in_execute = (state == mips_bus_pkg::state_execute);

    always_comb begin
        alu_op       = mips_isa_pkg::alu_add;
        alu_b        = rf.rt_data;
        dec_write    = 1'b0;
        dec_jump     = 1'b0;
        dec_jump_reg = 1'b0;
        dec_wr_addr  = ir.r.rd;
        dec_wr_data  = alu_result;

        case (ir.r.opcode)
            mips_isa_pkg::opcode_rtype: begin
                dec_write = 1'b1;
                case (ir.r.funct)
                    mips_isa_pkg::funct_addu: alu_op = mips_isa_pkg::alu_add;
                    mips_isa_pkg::funct_and:  alu_op = mips_isa_pkg::alu_and;
                    mips_isa_pkg::funct_or:   alu_op = mips_isa_pkg::alu_or;
                    mips_isa_pkg::funct_xor:  alu_op = mips_isa_pkg::alu_xor;
                    mips_isa_pkg::funct_jr: begin
                        dec_write    = 1'b0;
                        dec_jump_reg = 1'b1;
                    end
                    default: dec_write = 1'b0; // Unsupported, runs as a no-op
                endcase
            end
            mips_isa_pkg::opcode_j: begin
                dec_jump = 1'b1;
            end
            mips_isa_pkg::opcode_jal: begin
                dec_jump    = 1'b1;
                dec_write   = 1'b1;
                dec_wr_addr = mips_isa_pkg::reg_ra;
                dec_wr_data = pc_plus4; // Return address
            end
            mips_isa_pkg::opcode_addiu: begin
                alu_b       = {{16{ir.i.imm[15]}}, ir.i.imm}; // Sign-extended
                dec_write   = 1'b1;
                dec_wr_addr = ir.i.rt;
            end
            mips_isa_pkg::opcode_andi: begin
                alu_op      = mips_isa_pkg::alu_and;
                alu_b       = {16'h0000, ir.i.imm};
                dec_write   = 1'b1;
                dec_wr_addr = ir.i.rt;
            end
            mips_isa_pkg::opcode_ori: begin
                alu_op      = mips_isa_pkg::alu_or;
                alu_b       = {16'h0000, ir.i.imm};
                dec_write   = 1'b1;
                dec_wr_addr = ir.i.rt;
            end
            mips_isa_pkg::opcode_xori: begin
                alu_op      = mips_isa_pkg::alu_xor;
                alu_b       = {16'h0000, ir.i.imm};
                dec_write   = 1'b1;
                dec_wr_addr = ir.i.rt;
            end
            default: begin
            end
        endcase
    end

    // ------------------------------------------------------------
    // Register file and counter steering
    // ------------------------------------------------------------
    assign rf.rs_addr = ir.r.rs;
    assign rf.rt_addr = ir.r.rt;
    assign rf.wr_en   = in_execute && dec_write;
    assign rf.wr_addr = dec_wr_addr;
    assign rf.wr_data = dec_wr_data;

    assign pc_jump     = in_execute && dec_jump;
    assign pc_jump_reg = in_execute && dec_jump_reg;
    assign pc_advance  = in_execute && !dec_jump && !dec_jump_reg;
    assign jump_target = ir.j.target;

endmodule

// File: logic/mips_cpu_bus.sv
/*
 * Multicycle MIPS subset core with an Avalon read master
 * Joins control, program counter, register file and ALU
 */

`timescale 1ns/1ps

module mips_cpu_bus (
    input  logic                clk,
    input  logic                reset,
    output logic                active,
    output mips_bus_pkg::word_t register_v0,

    output mips_bus_pkg::word_t address,
    output logic                read,
    output logic                write,
    input  logic                waitrequest,
    output mips_bus_pkg::word_t writedata,
    output logic [3:0]          byteenable,
    input  mips_bus_pkg::word_t readdata
);

    mips_bus_pkg::word_t   pc;
    logic                  halted;
    logic                  pc_advance;
    logic                  pc_jump;
    logic                  pc_jump_reg;
    logic [25:0]           jump_target;
    mips_isa_pkg::alu_op_t alu_op;
    mips_bus_pkg::word_t   alu_b;
    mips_bus_pkg::word_t   alu_result;

    regfile_if rf_bus ();

    assign active    = !halted;
    assign address   = pc;          // Only instruction fetches use the bus
    assign write     = 1'b0;
    assign writedata = '0;

    cpu_control u_control (
        .clk         (clk),
        .reset       (reset),
        .halted      (halted),
        .pc          (pc),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .read        (read),
        .byteenable  (byteenable),
        .rf          (rf_bus.ctrl),
        .alu_op      (alu_op),
        .alu_b       (alu_b),
        .alu_result  (alu_result),
        .pc_advance  (pc_advance),
        .pc_jump     (pc_jump),
        .pc_jump_reg (pc_jump_reg),
        .jump_target (jump_target)
    );

    pc_counter u_pc (
        .clk       (clk),
        .reset     (reset),
        .advance   (pc_advance),
        .jump      (pc_jump),
        .jump_reg  (pc_jump_reg),
        .target    (jump_target),
        .reg_value (rf_bus.rs_data),  // JR source
        .pc        (pc),
        .halted    (halted)
    );

    reg_file u_regs (
        .clk         (clk),
        .reset       (reset),
        .rf          (rf_bus.regs),
        .register_v0 (register_v0)
    );

    alu u_alu (
        .a      (rf_bus.rs_data),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

endmodule

// File: test/tb_clock.sv
/*
 * Testbench clock source, 20 ns period
 */

`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk; // Half period
        end
    end

endmodule

// File: test/avalon_mem_model.sv
/*
 * Avalon instruction memory slave for the testbench
 * Zero-latency reads from reset_vector upward, waitrequest follows stall
 */

`timescale 1ns/1ps

module avalon_mem_model #(
    parameter int depth = 64
) (
    input  logic                clk,
    input  logic                load_en,
    input  logic [5:0]          load_index,
    input  mips_bus_pkg::word_t load_data,
    input  logic                stall,
    input  mips_bus_pkg::word_t address,
    input  logic                read,
    output logic                waitrequest,
    output mips_bus_pkg::word_t readdata
);

    mips_bus_pkg::word_t mem [depth];
    mips_bus_pkg::word_t offset;

    initial begin
        for (int n = 0; n < depth; n++) begin
            mem[n] = '0;
        end
    end

    // ------------------------------------------------------------
    // Program load port
    // ------------------------------------------------------------
    always @(posedge clk) begin
        if (load_en) begin
            mem[load_index] <= load_data;
        end
    end

    // ------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------
    assign offset      = address - mips_bus_pkg::reset_vector;
    assign waitrequest = stall;   // Random back-pressure from the testbench

    always_comb begin
        if (read && offset < 32'(depth * 4)) begin
            readdata = mem[offset[7:2]];
        end else begin
            readdata = '0;        // Unmapped or idle
        end
    end

endmodule

// File: test/tb_mips_cpu_bus.sv
/*
 * Testbench for the multicycle MIPS subset core
 * Directed programs, run with and without random waitrequest
 */

`timescale 1ns/1ps

module tb_mips_cpu_bus;

    localparam int mem_words  = 64;
    localparam int halt_limit = 2000;   // Cycles allowed per program

    logic                clk;
    logic                reset;
    logic                active;
    mips_bus_pkg::word_t register_v0;
    mips_bus_pkg::word_t address;
    logic                read;
    logic                write;
    logic                waitrequest;
    mips_bus_pkg::word_t writedata;
    logic [3:0]          byteenable;
    mips_bus_pkg::word_t readdata;

    logic                load_en;
    logic [5:0]          load_index;
    mips_bus_pkg::word_t load_data;
    logic                stall;
    logic                stall_en;
    int                  stalled_fetches = 0;
    mips_bus_pkg::word_t program_q[$];

    tb_clock u_clock (.clk(clk));

    avalon_mem_model #(.depth(mem_words)) u_mem (
        .clk         (clk),
        .load_en     (load_en),
        .load_index  (load_index),
        .load_data   (load_data),
        .stall       (stall),
        .address     (address),
        .read        (read),
        .waitrequest (waitrequest),
        .readdata    (readdata)
    );

    mips_cpu_bus dut0 (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .read        (read),
        .write       (write),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    // Random waitrequest, the only user of $urandom
    initial begin
        void'($urandom(32'hde6c0b93));
        stall <= 1'b0;
        forever begin
            @(posedge clk);
            stall <= stall_en && ($urandom % 2 == 1);
        end
    end

    always @(posedge clk) begin
        if (read === 1'b1 && waitrequest === 1'b1) begin
            stalled_fetches <= stalled_fetches + 1;
        end
    end

    // ------------------------------------------------------------
    // Error handling and compares
    // ------------------------------------------------------------
    task automatic stop_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic compare_word(input mips_bus_pkg::word_t actual,
                                input mips_bus_pkg::word_t expected, input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s is %h, expected %h", $time, what, actual, expected);
            stop_run();
        end
    endtask

    task automatic compare_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s is %b, expected %b", $time, what, actual, expected);
            stop_run();
        end
    endtask

    // ------------------------------------------------------------
    // Instruction encoding through the union views
    // ------------------------------------------------------------
    function automatic mips_bus_pkg::word_t rtype_word(input mips_isa_pkg::funct_t funct,
                                                       input int rs, input int rt, input int rd);
        mips_isa_pkg::instr_t w;
        w.r.opcode = mips_isa_pkg::opcode_rtype;
        w.r.rs     = 5'(rs);
        w.r.rt     = 5'(rt);
        w.r.rd     = 5'(rd);
        w.r.shamt  = 5'd0;
        w.r.funct  = funct;
        return w;
    endfunction

    function automatic mips_bus_pkg::word_t itype_word(input mips_isa_pkg::opcode_t op,
                                                       input int rs, input int rt,
                                                       input logic [15:0] imm);
        mips_isa_pkg::instr_t w;
        w.i.opcode = op;
        w.i.rs     = 5'(rs);
        w.i.rt     = 5'(rt);
        w.i.imm    = imm;
        return w;
    endfunction

    function automatic mips_bus_pkg::word_t word_address(input int index);
        return mips_bus_pkg::reset_vector + 32'(4 * index);
    endfunction

    function automatic mips_bus_pkg::word_t jump_word(input mips_isa_pkg::opcode_t op,
                                                      input int index);
        mips_isa_pkg::instr_t w;
        w.j.opcode = op;
        w.j.target = 26'(word_address(index) >> 2);   // Word address, low 28 bits
        return w;
    endfunction

    // ------------------------------------------------------------
    // Program load, reset and run
    // ------------------------------------------------------------
    task automatic load_program();
        for (int n = 0; n < mem_words; n++) begin
            @(posedge clk);
            load_en    <= 1'b1;
            load_index <= 6'(n);
            load_data  <= (n < program_q.size()) ? program_q[n] : '0;
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        for (int n = 0; n < 16; n++) begin
            @(negedge clk);
            compare_bit(read, 1'b0, "read during reset");
            @(posedge clk);
        end
        reset <= 1'b0;
        @(negedge clk);                                 // First fetch cycle
        compare_word(address, mips_bus_pkg::reset_vector, "address after reset");
        compare_bit(active, 1'b1, "active after reset");
        compare_bit(&byteenable, 1'b1, "byteenable on fetch");
        compare_bit(write, 1'b0, "write on fetch");
        compare_word(writedata, 32'h0000_0000, "writedata on fetch");
    endtask

    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        while (active === 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > halt_limit) begin
                $display("Timeout at %0t: core never halted within %0d cycles",
                         $time, halt_limit);
                stop_run();
            end
        end
    endtask

    task automatic run_program(input mips_bus_pkg::word_t expected, input string name);
        load_program();
        apply_reset();
        wait_for_halt();
        compare_word(register_v0, expected, {name, " register_v0"});
        compare_bit(active, 1'b0, {name, " active"});
        for (int n = 0; n < 8; n++) begin
            @(negedge clk);
            compare_bit(read, 1'b0, {name, " read after halt"});
            compare_bit(|byteenable, 1'b0, {name, " byteenable after halt"});
            compare_bit(active, 1'b0, {name, " active after halt"});
        end
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic alu_ops_test();
        mips_bus_pkg::word_t a;
        mips_bus_pkg::word_t b;
        mips_bus_pkg::word_t expected;
        a        = 32'h0000_7abc;   // Positive, so ADDIU extension is invisible
        b        = 32'h0000_5a5a;
        expected = (((a + b) + (a & b)) ^ (a | b)) + (a ^ b);
        program_q.delete();
        program_q.push_back(itype_word(mips_isa_pkg::opcode_addiu, 0, 8, 16'h7abc));
        program_q.push_back(itype_word(mips_isa_pkg::opcode_ori, 0, 9, 16'h5a5a));
        program_q.push_back(rtype_word(mips_isa_pkg::funct_addu, 8, 9, 10));
        program_q.push_back(rtype_word(mips_isa_pkg::funct_and, 8, 9, 11));
        program_q.push_back(rtype_word(mips_isa_pkg::funct_or, 8, 9, 12));
        program_q.push_back(rtype_word(mips_isa_pkg::funct_xor, 8, 9, 13));
        program_q.push_back(rtype_word(mips_isa_pkg::funct_addu, 10, 11, 14));
        program_q.push_back(rtype_word(mips_isa_pkg::funct_xor, 14, 12, 14));
        program_q.push_back(rtype_word(mips_isa_pkg::funct_addu, 14, 13, 2));
        program_q.push_back(rtype_word(mips_isa_pkg::funct_jr, 0, 0, 0));
        run_program(expected, "alu ops");
    endtask

    task automatic immediate_test();
        mips_bus_pkg::word_t neg;
        mips_bus_pkg::word_t expected;
        neg      = 32'($signed(16'hfff0));                 // Sign-extended ADDIU
        expected = ((neg & 32'h0000_8f0f) + 32'h0000_8001) ^ (neg ^ 32'h0000_8421);
        program_q.delete();
        program_q.push_back(itype_word(mips_isa_pkg::opcode_addiu, 0, 8, 16'hfff0));
        program_q.push_back(itype_word(mips_isa_pkg::opcode_andi, 8, 9, 16'h8f0f));
        program_q.push_back(itype_word(mips_isa_pkg::opcode_ori, 0, 10, 16'h8001));
        program_q.push_back(itype_word(mips_isa_pkg::opcode_xori, 8, 11, 16'h8421));
        program_q.push_back(rtype_word(mips_isa_pkg::funct_addu, 9, 10, 12));
        program_q.push_back(rtype_word(mips_isa_pkg::funct_xor, 12, 11, 2));
        program_q.push_back(rtype_word(mips_isa_pkg::funct_jr, 0, 0, 0));
        run_program(expected, "immediates");
    endtask

    task automatic jump_link_test();
        mips_bus_pkg::word_t expected;
        // JAL sits at index 1, so its return address is the word after it
        expected = ((32'd1 + 32'h10) ^ (word_address(1) + 32'd4)) + 32'h100;
        program_q.delete();
        program_q.push_back(itype_word(mips_isa_pkg::opcode_addiu, 0, 2, 16'h0001));
        program_q.push_back(jump_word(mips_isa_pkg::opcode_jal, 5));
        program_q.push_back(itype_word(mips_isa_pkg::opcode_addiu, 2, 2, 16'h0100));
        program_q.push_back(rtype_word(mips_isa_pkg::funct_jr, 0, 0, 0));
        program_q.push_back(itype_word(mips_isa_pkg::opcode_addiu, 2, 2, 16'h0040));
        program_q.push_back(itype_word(mips_isa_pkg::opcode_addiu, 2, 2, 16'h0010));
        program_q.push_back(jump_word(mips_isa_pkg::opcode_j, 8));
        program_q.push_back(itype_word(mips_isa_pkg::opcode_addiu, 2, 2, 16'h0020));
        program_q.push_back(rtype_word(mips_isa_pkg::funct_xor, 2, 31, 2));
        program_q.push_back(rtype_word(mips_isa_pkg::funct_jr, 31, 0, 0));
        run_program(expected, "jump and link");
    endtask

    task automatic halt_test();
        program_q.delete();
        program_q.push_back(itype_word(mips_isa_pkg::opcode_addiu, 0, 8, 16'h0005));
        program_q.push_back(rtype_word(mips_isa_pkg::funct_xor, 8, 8, 8));   // r8 cleared
        program_q.push_back(itype_word(mips_isa_pkg::opcode_addiu, 0, 2, 16'h0055));
        program_q.push_back(rtype_word(mips_isa_pkg::funct_jr, 8, 0, 0));
        run_program(32'h0000_0055, "halt on jr");
    endtask

    task automatic zero_reg_test();
        program_q.delete();
        program_q.push_back(itype_word(mips_isa_pkg::opcode_addiu, 0, 2, 16'h0033));
        program_q.push_back(itype_word(mips_isa_pkg::opcode_addiu, 0, 0, 16'h0077));
        program_q.push_back(itype_word(mips_isa_pkg::opcode_ori, 0, 0, 16'h0001));
        program_q.push_back(rtype_word(mips_isa_pkg::funct_addu, 0, 0, 2));
        program_q.push_back(rtype_word(mips_isa_pkg::funct_jr, 0, 0, 0));
        run_program(32'h0000_0000, "register zero");
    endtask

    task automatic stall_test();
        @(posedge clk);
        stall_en <= 1'b1;
        alu_ops_test();
        jump_link_test();
        if (stalled_fetches == 0) begin
            $display("No fetch saw waitrequest while random stalls were enabled");
            stop_run();
        end
        @(posedge clk);
        stall_en <= 1'b0;
    endtask

    initial begin
        reset      <= 1'b1;
        load_en    <= 1'b0;
        load_index <= '0;
        load_data  <= '0;
        stall_en   <= 1'b0;
        alu_ops_test();
        immediate_test();
        jump_link_test();
        halt_test();
        zero_reg_test();
        stall_test();
        $display("sim passed");
        $finish;
    end

endmodule

// File: flist.f
logic/mips_bus_pkg.sv
logic/mips_isa_pkg.sv
logic/regfile_if.sv
logic/reg_file.sv
logic/alu.sv
logic/pc_counter.sv
logic/cpu_control.sv
logic/mips_cpu_bus.sv
test/tb_clock.sv
test/avalon_mem_model.sv
test/tb_mips_cpu_bus.sv

// File: Makefile
TOP = tb_mips_cpu_bus

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -f flist.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee /dev/stderr | grep -qx "sim passed"

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
